// ==== hdl/rvcDecPkg.sv ====
// RVC decode types
// instruction format views, register ids and micro-op encodings

`include "rvcDec_config.svh"

package rvcDecPkg;

	typedef struct packed {
		logic [3:0] funct4;
		logic [4:0] rs1;	// also rd
		logic [4:0] rs2;
		logic [1:0] op;
	} crFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic immHi;	// imm[5]
		logic [4:0] rd;
		logic [4:0] immLo;	// imm[4:0]
		logic [1:0] op;
	} ciFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [5:0] imm;
		logic [4:0] rs2;
		logic [1:0] op;
	} cssFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [7:0] imm;
		logic [2:0] rdP;
		logic [1:0] op;
	} ciwFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [2:0] immHi;
		logic [2:0] rs1P;
		logic [1:0] immLo;
		logic [2:0] rdP;
		logic [1:0] op;
	} clFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [2:0] immHi;	// funct6 low bits on arithmetic forms
		logic [2:0] rs1P;
		logic [1:0] immLo;	// funct2 on arithmetic forms
		logic [2:0] rs2P;
		logic [1:0] op;
	} csFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [2:0] offHi;
		logic [2:0] rs1P;
		logic [4:0] offLo;
		logic [1:0] op;
	} cbFmt_t;

	typedef struct packed {
		logic [2:0] funct3;
		logic [10:0] target;
		logic [1:0] op;
	} cjFmt_t;

	// one 16-bit word, read through whichever layout the opcode selects
	typedef union packed {
		logic [15:0] raw;
		crFmt_t cr;
		ciFmt_t ci;
		cssFmt_t css;
		ciwFmt_t ciw;
		clFmt_t cl;
		csFmt_t cs;
		cbFmt_t cb;
		cjFmt_t cj;
	} rvcWord_t;

	typedef logic [`RVC_GPR_W-1:0] gprSel_t;

	localparam gprSel_t GR_SP = `RVC_GPR_W'(2);	// plain x2
	localparam gprSel_t GR_ZZR = `RVC_GPR_W'(32);	// reads as zero
	localparam gprSel_t GR_IMM = `RVC_GPR_W'(33);	// immediate operand
	localparam gprSel_t GR_PC = `RVC_GPR_W'(34);

	typedef enum logic [3:0] {
		FMID_INV = 4'd0,
		FMID_REGREG,
		FMID_REGIMM,
		FMID_LDSTDISP,
		FMID_SPDISP,
		FMID_PCDISP,
		FMID_REG,
		FMID_Z
	} fmid_t;

	typedef enum logic [5:0] {
		UCMD_INVOP = 6'd0,
		UCMD_ALU,
		UCMD_MOV,
		UCMD_LD,
		UCMD_ST,
		UCMD_BRA,
		UCMD_JMP,
		UCMD_TRAP
	} nmid_t;

	typedef enum logic [2:0] {
		IXC_AL = 3'd0,
		IXC_EQZ,
		IXC_NEZ
	} ccty_t;

	typedef enum logic [5:0] {
		IX_ADD = 6'd0,
		IX_SUB,
		IX_AND,
		IX_OR,
		IX_XOR,
		IX_SLL,
		IX_SRL,
		IX_SRA,
		IX_LUI,
		IX_WORD	// 32-bit memory access
	} alux_t;

endpackage

// ==== hdl/rvcDec_config.svh ====
// RVC decode stage sizing
// widths shared by the package and the decode blocks

`ifndef RVC_DEC_CONFIG_SVH
`define RVC_DEC_CONFIG_SVH

// internal register selector, covers x0..x31 and the special ids
`define RVC_GPR_W 6

// sign-extended immediate handed to execute
`define RVC_IMM_W 33

// processor mode word
`define RVC_MODE_W 4

// mode word bit positions
`define RVC_MODE_USER 0
`define RVC_MODE_DBG 1

`endif

// ==== hdl/rvcDecodeLatch.sv ====
// RVC decode output register
// loads the micro-op on issue, freezes under hold,
// keeps a sticky record of the first illegal word

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcDecodeLatch (
	input logic clock,
	input logic rstN,
	input logic issue,
	input logic hold,
	input rvcDecPkg::rvcWord_t istrWord,
	input rvcDecPkg::fmid_t fmid,
	input rvcDecPkg::nmid_t nmid,
	input rvcDecPkg::ccty_t ccty,
	input rvcDecPkg::alux_t aluIx,
	input rvcDecPkg::gprSel_t regN,
	input rvcDecPkg::gprSel_t regM,
	input rvcDecPkg::gprSel_t regO,
	input logic [`RVC_IMM_W-1:0] imm,
	output logic idValid,
	output rvcDecPkg::gprSel_t idRegN,
	output rvcDecPkg::gprSel_t idRegM,
	output rvcDecPkg::gprSel_t idRegO,
	output logic [`RVC_IMM_W-1:0] idImm,
	output logic [8:0] idUCmd,
	output logic [8:0] idUIxt,
	output logic idInvalid,
	output logic illegalSeen,
	output logic [15:0] illegalWord
);

	logic accept;
	logic badOp;
	logic wordAcc;

	assign accept = issue && !hold;
	assign badOp = (fmid == rvcDecPkg::FMID_INV);
	assign wordAcc = (aluIx == rvcDecPkg::IX_WORD);	// memory word flag

	always_ff @(posedge clock) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idRegN <= rvcDecPkg::GR_ZZR;
			idRegM <= rvcDecPkg::GR_ZZR;
			idRegO <= rvcDecPkg::GR_ZZR;
			idImm <= '0;
			idUCmd <= {rvcDecPkg::IXC_AL, rvcDecPkg::UCMD_INVOP};
			idUIxt <= '0;
			idInvalid <= 1'b0;
		end else if (!hold) begin
			idValid <= issue;
			if (issue) begin
				idRegN <= regN;
				idRegM <= regM;
				idRegO <= regO;
				idImm <= imm;
				idUCmd <= {ccty, nmid};	// condition then operation
				idUIxt <= {wordAcc, 2'b00, aluIx};
				idInvalid <= badOp;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			illegalSeen <= 1'b0;
			illegalWord <= '0;
		end else if (accept && badOp && !illegalSeen) begin	// first one only
			illegalSeen <= 1'b1;
			illegalWord <= istrWord.raw;
		end
	end

endmodule

// ==== hdl/rvcDecodeStage.sv ====
// RVC decode stage top
// two parallel decoders feeding the output register

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcDecodeStage (
	input logic clock,
	input logic rstN,
	input rvcDecPkg::rvcWord_t istrWord,
	input logic issue,
	input logic [`RVC_MODE_W-1:0] srMod,
	input logic hold,
	output logic idValid,
	output rvcDecPkg::gprSel_t idRegN,
	output rvcDecPkg::gprSel_t idRegM,
	output rvcDecPkg::gprSel_t idRegO,
	output logic [`RVC_IMM_W-1:0] idImm,
	output logic [8:0] idUCmd,
	output logic [8:0] idUIxt,
	output logic idInvalid,
	output logic illegalSeen,
	output logic [15:0] illegalWord
);

	rvcDecPkg::fmid_t fmid;
	rvcDecPkg::nmid_t nmid;
	rvcDecPkg::ccty_t ccty;
	rvcDecPkg::alux_t aluIx;
	logic memWord;
	rvcDecPkg::gprSel_t regN;
	rvcDecPkg::gprSel_t regM;
	rvcDecPkg::gprSel_t regO;
	logic [`RVC_IMM_W-1:0] imm;

	rvcFormatDecode uFormat (
		.istrWord(istrWord),
		.srMod(srMod),
		.fmid(fmid),
		.nmid(nmid),
		.ccty(ccty),
		.aluIx(aluIx),
		.memWord(memWord)
	);

	rvcOperandSelect uOperand (
		.istrWord(istrWord),
		.fmid(fmid),
		.memWord(memWord),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm)
	);

	rvcDecodeLatch uLatch (
		.clock(clock),
		.rstN(rstN),
		.issue(issue),
		.hold(hold),
		.istrWord(istrWord),
		.fmid(fmid),
		.nmid(nmid),
		.ccty(ccty),
		.aluIx(aluIx),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt),
		.idInvalid(idInvalid),
		.illegalSeen(illegalSeen),
		.illegalWord(illegalWord)
	);

endmodule

// ==== hdl/rvcFormatDecode.sv ====
// RVC format classifier
// opcode and funct match giving format, operation, condition and sub-op,
// with the reserved-encoding rules and the user-mode trap check

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcFormatDecode (
	input rvcDecPkg::rvcWord_t istrWord,
	input logic [`RVC_MODE_W-1:0] srMod,
	output rvcDecPkg::fmid_t fmid,
	output rvcDecPkg::nmid_t nmid,
	output rvcDecPkg::ccty_t ccty,
	output rvcDecPkg::alux_t aluIx,
	output logic memWord
);

	logic usrReject;	// form needs supervisor or debug
	logic privOk;

	// supervisor mode, or user mode with the debug grant
	assign privOk = !srMod[`RVC_MODE_USER] || srMod[`RVC_MODE_DBG];

	always_comb begin
		fmid = rvcDecPkg::FMID_INV;
		nmid = rvcDecPkg::UCMD_INVOP;
		ccty = rvcDecPkg::IXC_AL;
		aluIx = rvcDecPkg::IX_ADD;
		memWord = 1'b0;
		usrReject = 1'b0;

		case ({istrWord.ci.op, istrWord.ci.funct3})
			5'b00_000: begin	// c.addi4spn
				if (istrWord.ciw.imm != 8'd0) begin
					fmid = rvcDecPkg::FMID_SPDISP;
					nmid = rvcDecPkg::UCMD_ALU;
				end
			end
			5'b00_010, 5'b00_110: begin	// c.lw, c.sw
				fmid = rvcDecPkg::FMID_LDSTDISP;
				if (istrWord.ci.funct3[2])
					nmid = rvcDecPkg::UCMD_ST;
				else
					nmid = rvcDecPkg::UCMD_LD;
				aluIx = rvcDecPkg::IX_WORD;
				memWord = 1'b1;
			end
			5'b01_000: begin	// c.addi
				fmid = rvcDecPkg::FMID_REGIMM;
				nmid = rvcDecPkg::UCMD_ALU;
			end
			5'b01_010: begin	// c.li
				fmid = rvcDecPkg::FMID_REGIMM;
				nmid = rvcDecPkg::UCMD_MOV;
			end
			5'b01_011: begin	// c.lui, c.addi16sp is not supported
				if ({istrWord.ci.immHi, istrWord.ci.immLo} != 6'd0 &&
						istrWord.ci.rd != 5'd0 && istrWord.ci.rd != 5'd2) begin
					fmid = rvcDecPkg::FMID_REGIMM;
					nmid = rvcDecPkg::UCMD_MOV;
					aluIx = rvcDecPkg::IX_LUI;
				end
			end
			5'b01_100: begin
				case (istrWord.cb.offHi[1:0])
					2'b00, 2'b01: begin	// c.srli, c.srai
						if (!istrWord.cb.offHi[2]) begin	// shamt[5] is rv64 only
							fmid = rvcDecPkg::FMID_REGIMM;
							nmid = rvcDecPkg::UCMD_ALU;
							if (istrWord.cb.offHi[0])
								aluIx = rvcDecPkg::IX_SRA;
							else
								aluIx = rvcDecPkg::IX_SRL;
						end
					end
					2'b10: begin	// c.andi
						fmid = rvcDecPkg::FMID_REGIMM;
						nmid = rvcDecPkg::UCMD_ALU;
						aluIx = rvcDecPkg::IX_AND;
					end
					default: begin	// register arithmetic
						if (!istrWord.cs.immHi[2]) begin	// subw/addw dropped
							fmid = rvcDecPkg::FMID_REGREG;
							nmid = rvcDecPkg::UCMD_ALU;
							case (istrWord.cs.immLo)
								2'b00: aluIx = rvcDecPkg::IX_SUB;
								2'b01: aluIx = rvcDecPkg::IX_XOR;
								2'b10: aluIx = rvcDecPkg::IX_OR;
								default: aluIx = rvcDecPkg::IX_AND;
							endcase
						end
					end
				endcase
			end
			5'b01_101: begin	// c.j
				fmid = rvcDecPkg::FMID_PCDISP;
				nmid = rvcDecPkg::UCMD_JMP;
			end
			5'b01_110, 5'b01_111: begin	// c.beqz, c.bnez
				fmid = rvcDecPkg::FMID_PCDISP;
				nmid = rvcDecPkg::UCMD_BRA;
				if (istrWord.ci.funct3[0])
					ccty = rvcDecPkg::IXC_NEZ;
				else
					ccty = rvcDecPkg::IXC_EQZ;
			end
			5'b10_000: begin	// c.slli
				if (!istrWord.ci.immHi) begin
					fmid = rvcDecPkg::FMID_REGIMM;
					nmid = rvcDecPkg::UCMD_ALU;
					aluIx = rvcDecPkg::IX_SLL;
				end
			end
			5'b10_010, 5'b10_110: begin	// c.lwsp, c.swsp
				fmid = rvcDecPkg::FMID_SPDISP;
				if (istrWord.ci.funct3[2])
					nmid = rvcDecPkg::UCMD_ST;
				else
					nmid = rvcDecPkg::UCMD_LD;
				aluIx = rvcDecPkg::IX_WORD;
				memWord = 1'b1;
			end
			5'b10_100: begin
				if (istrWord.cr.rs2 != 5'd0) begin	// c.mv, c.add
					fmid = rvcDecPkg::FMID_REGREG;
					if (istrWord.cr.funct4[0])
						nmid = rvcDecPkg::UCMD_ALU;
					else
						nmid = rvcDecPkg::UCMD_MOV;
				end else if (!istrWord.cr.funct4[0]) begin
					if (istrWord.cr.rs1 != 5'd0) begin	// c.jr
						fmid = rvcDecPkg::FMID_REG;
						nmid = rvcDecPkg::UCMD_JMP;
					end
				end else if (istrWord.cr.rs1 == 5'd0) begin	// c.ebreak
					fmid = rvcDecPkg::FMID_Z;
					nmid = rvcDecPkg::UCMD_TRAP;
					usrReject = 1'b1;
				end
			end
			default: ;	// fp, rv64 forms, c.jal, 32-bit words
		endcase

		if (usrReject && !privOk) begin
			fmid = rvcDecPkg::FMID_INV;
			nmid = rvcDecPkg::UCMD_INVOP;
		end
	end

endmodule

// ==== hdl/rvcOperandSelect.sv ====
// RVC operand builder
// register selectors and the 33-bit immediate per format id

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcOperandSelect (
	input rvcDecPkg::rvcWord_t istrWord,
	input rvcDecPkg::fmid_t fmid,
	input logic memWord,
	output rvcDecPkg::gprSel_t regN,
	output rvcDecPkg::gprSel_t regM,
	output rvcDecPkg::gprSel_t regO,
	output logic [`RVC_IMM_W-1:0] imm
);

	// 5-bit field, x0 reads as the zero register
	function automatic rvcDecPkg::gprSel_t fullReg(input logic [4:0] f);
		return (f == 5'd0) ? rvcDecPkg::GR_ZZR : {1'b0, f};
	endfunction

	// 3-bit field covers x8..x15
	function automatic rvcDecPkg::gprSel_t primeReg(input logic [2:0] f);
		return {3'b001, f};
	endfunction

	logic [1:0] quad;
	logic [2:0] f3;
	logic [15:0] w;	// raw bits for the scrambles
	rvcDecPkg::gprSel_t selRd;
	rvcDecPkg::gprSel_t selRs2;
	rvcDecPkg::gprSel_t selRdP;
	rvcDecPkg::gprSel_t selRs1P;
	logic [`RVC_IMM_W-1:0] immCi;
	logic [`RVC_IMM_W-1:0] immShamt;
	logic [`RVC_IMM_W-1:0] immLui;
	logic [`RVC_IMM_W-1:0] immCiw;
	logic [`RVC_IMM_W-1:0] immCl;
	logic [`RVC_IMM_W-1:0] immLwsp;
	logic [`RVC_IMM_W-1:0] immSwsp;
	logic [`RVC_IMM_W-1:0] immCj;
	logic [`RVC_IMM_W-1:0] immCb;

	assign quad = istrWord.ci.op;
	assign f3 = istrWord.ci.funct3;
	assign w = istrWord.raw;

	assign selRd = fullReg(istrWord.ci.rd);	// also cr rs1
	assign selRs2 = fullReg(istrWord.css.rs2);
	assign selRdP = primeReg(istrWord.cl.rdP);	// rd' and rs2' share bits 4:2
	assign selRs1P = primeReg(istrWord.cb.rs1P);

	assign immCi = {{27{istrWord.ci.immHi}}, istrWord.ci.immHi, istrWord.ci.immLo};
	assign immShamt = {27'd0, istrWord.ci.immHi, istrWord.ci.immLo};
	assign immLui = {{15{istrWord.ci.immHi}}, istrWord.ci.immHi, istrWord.ci.immLo, 12'd0};
	assign immCiw = {23'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};	// nzuimm[9:2]
	assign immCl = {26'd0, w[5], w[12:10], w[6], 2'b00};
	assign immLwsp = {25'd0, w[3:2], w[12], w[6:4], 2'b00};
	assign immSwsp = {25'd0, w[8:7], w[12:9], 2'b00};
	assign immCj = {{21{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
	assign immCb = {{24{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};

	always_comb begin
		regN = rvcDecPkg::GR_ZZR;
		regM = rvcDecPkg::GR_ZZR;
		regO = rvcDecPkg::GR_ZZR;
		imm = '0;

		case (fmid)
			rvcDecPkg::FMID_REGREG: begin
				if (quad == 2'b10) begin	// c.mv leaves M empty
					regN = selRd;
					regM = istrWord.cr.funct4[0] ? selRd : rvcDecPkg::GR_ZZR;
					regO = selRs2;
				end else begin
					regN = selRs1P;
					regM = selRs1P;
					regO = selRdP;
				end
			end
			rvcDecPkg::FMID_REGIMM: begin
				regO = rvcDecPkg::GR_IMM;
				if (quad == 2'b01 && f3[2]) begin	// srli, srai, andi
					regN = selRs1P;
					regM = selRs1P;
					imm = (istrWord.cb.offHi[1:0] == 2'b10) ? immCi : immShamt;
				end else if (quad == 2'b01 && f3[1]) begin	// c.li, c.lui
					regN = selRd;
					imm = f3[0] ? immLui : immCi;
				end else begin	// c.addi, c.slli
					regN = selRd;
					regM = selRd;
					imm = (quad == 2'b10) ? immShamt : immCi;
				end
			end
			rvcDecPkg::FMID_LDSTDISP: begin
				regN = selRdP;
				regM = selRs1P;
				regO = rvcDecPkg::GR_IMM;
				imm = immCl;
			end
			rvcDecPkg::FMID_SPDISP: begin
				regM = rvcDecPkg::GR_SP;
				regO = rvcDecPkg::GR_IMM;
				if (!memWord) begin	// c.addi4spn
					regN = selRdP;
					imm = immCiw;
				end else if (f3[2]) begin
					regN = selRs2;
					imm = immSwsp;
				end else begin
					regN = selRd;
					imm = immLwsp;
				end
			end
			rvcDecPkg::FMID_PCDISP: begin
				regM = rvcDecPkg::GR_PC;
				regO = rvcDecPkg::GR_IMM;
				if (istrWord.cj.funct3 == 3'b101) begin
					imm = immCj;
				end else begin	// branch tests rs1'
					regN = selRs1P;
					imm = immCb;
				end
			end
			rvcDecPkg::FMID_REG: regM = selRd;	// jump target
			default: ;	// invalid and trap carry no operands
		endcase
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the RVC decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module rvcDecodeStage_tb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== sim/rvcDecodeStage_props.sv ====
// RVC decode stage properties
// reset, hold freeze and sticky illegal record on the top-level ports

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcDecodeStage_props (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic idValid,
	input logic [`RVC_GPR_W-1:0] idRegN,
	input logic [`RVC_GPR_W-1:0] idRegM,
	input logic [`RVC_GPR_W-1:0] idRegO,
	input logic [`RVC_IMM_W-1:0] idImm,
	input logic [8:0] idUCmd,
	input logic [8:0] idUIxt,
	input logic idInvalid,
	input logic illegalSeen
);

	resetClearsValid: assert property (@(posedge clock) !rstN |=> !idValid)
		else $error("idValid high after a reset edge");

	// whole micro-op frozen for the cycle after a hold
	holdFreezes: assert property (@(posedge clock) disable iff (!rstN)
			hold |=> $stable({idValid, idRegN, idRegM, idRegO, idImm, idUCmd, idUIxt, idInvalid}))
		else $error("decode outputs changed while hold was high");

	stickyIllegal: assert property (@(posedge clock) disable iff (!rstN)
			illegalSeen |=> illegalSeen)
		else $error("illegalSeen fell without a reset");

endmodule

bind rvcDecodeStage rvcDecodeStage_props uProps (
	.clock(clock),
	.rstN(rstN),
	.hold(hold),
	.idValid(idValid),
	.idRegN(idRegN),
	.idRegM(idRegM),
	.idRegO(idRegO),
	.idImm(idImm),
	.idUCmd(idUCmd),
	.idUIxt(idUIxt),
	.idInvalid(idInvalid),
	.illegalSeen(illegalSeen)
);

// ==== sim/rvcDecodeStage_tb.sv ====
// RVC decode stage testbench
// directed tests with LFSR operands, checked against a reference decoder

`timescale 1ns/1ps
`include "rvcDec_config.svh"

module rvcDecodeStage_tb;

	localparam int ROUNDS = 6;
	localparam int TEST_CYCLES = 4 + ROUNDS * 22 + 13 + 6 + 4;	// one cycle per issued word
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
	localparam logic [3:0] SUPER_MODE = 4'b0000;
	localparam logic [3:0] USER_MODE = 4'(1 << `RVC_MODE_USER);
	localparam logic [3:0] DEBUG_MODE = USER_MODE | 4'(1 << `RVC_MODE_DBG);
	localparam logic [15:0] FIRST_BAD = 16'h6111;	// c.lui x2, really c.addi16sp
	localparam logic [15:0] BAD_WORDS [10] = '{16'h0000, 16'h000C, 16'h6281, 16'h8002,
		16'h9002, 16'h2000, 16'h2001, 16'h9082, 16'h0013, 16'h9C89};

	logic clock;
	logic rstN;
	logic [15:0] istrWord;
	logic issue;
	logic [`RVC_MODE_W-1:0] srMod;
	logic hold;
	logic idValid;
	rvcDecPkg::gprSel_t idRegN;
	rvcDecPkg::gprSel_t idRegM;
	rvcDecPkg::gprSel_t idRegO;
	logic [`RVC_IMM_W-1:0] idImm;
	logic [8:0] idUCmd;
	logic [8:0] idUIxt;
	logic idInvalid;
	logic illegalSeen;
	logic [15:0] illegalWord;

	logic [5:0] expOp;
	logic [2:0] expCc;
	logic [5:0] expIx;
	logic [5:0] expN;
	logic [5:0] expM;
	logic [5:0] expO;
	logic [`RVC_IMM_W-1:0] expImm;
	logic expMem;
	logic [15:0] lfsr;
	int cycles;
	int checks;
	int errors;
	int tests;

	rvcDecodeStage dut (
		.clock(clock),
		.rstN(rstN),
		.istrWord(istrWord),
		.issue(issue),
		.srMod(srMod),
		.hold(hold),
		.idValid(idValid),
		.idRegN(idRegN),
		.idRegM(idRegM),
		.idRegO(idRegO),
		.idImm(idImm),
		.idUCmd(idUCmd),
		.idUIxt(idUIxt),
		.idInvalid(idInvalid),
		.illegalSeen(illegalSeen),
		.illegalWord(illegalWord)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [5:0] fullSel(input logic [4:0] f);
		return (f == 5'd0) ? rvcDecPkg::GR_ZZR : 6'(f);
	endfunction

	function automatic logic [5:0] compactSel(input logic [2:0] f);
		return 6'd8 + 6'(f);	// x8..x15
	endfunction

	function automatic void setExpected(input logic [5:0] op, input logic [5:0] ix,
			input logic [5:0] n, input logic [5:0] m, input logic [5:0] o, input logic [32:0] im);
		expOp = op;
		expCc = rvcDecPkg::IXC_AL;
		expIx = ix;
		expN = n;
		expM = m;
		expO = o;
		expImm = im;
		expMem = (op == rvcDecPkg::UCMD_LD) || (op == rvcDecPkg::UCMD_ST);
	endfunction

	// expected micro-op from the RVC encoding rules
	function automatic void refDecode(input logic [15:0] w, input logic [3:0] mode);
		logic [11:0] off;
		logic [5:0] ci6;
		logic [5:0] rd;
		logic [5:0] rs2;
		logic [5:0] rdP;
		logic [5:0] rs1P;
		logic [5:0] arIx;
		logic privOk;
		off = '0;
		ci6 = {w[12], w[6:2]};
		rd = fullSel(w[11:7]);
		rs2 = fullSel(w[6:2]);
		rdP = compactSel(w[4:2]);
		rs1P = compactSel(w[9:7]);
		privOk = !mode[`RVC_MODE_USER] || mode[`RVC_MODE_DBG];
		case (w[6:5])
			2'b00: arIx = rvcDecPkg::IX_SUB;
			2'b01: arIx = rvcDecPkg::IX_XOR;
			2'b10: arIx = rvcDecPkg::IX_OR;
			default: arIx = rvcDecPkg::IX_AND;
		endcase
		setExpected(rvcDecPkg::UCMD_INVOP, rvcDecPkg::IX_ADD, rvcDecPkg::GR_ZZR,
			rvcDecPkg::GR_ZZR, rvcDecPkg::GR_ZZR, '0);
		case ({w[1:0], w[15:13]})
			5'b00_000: begin	// nzuimm[5:4|9:6|2|3]
				off[5:4] = w[12:11];
				off[9:6] = w[10:7];
				off[2] = w[6];
				off[3] = w[5];
				if (off != 12'd0)
					setExpected(rvcDecPkg::UCMD_ALU, rvcDecPkg::IX_ADD, rdP, 6'd2,
						rvcDecPkg::GR_IMM, {21'd0, off});
			end
			5'b00_010, 5'b00_110: begin	// uimm[5:3] then [2|6]
				off[5:3] = w[12:10];
				off[2] = w[6];
				off[6] = w[5];
				setExpected(w[15] ? rvcDecPkg::UCMD_ST : rvcDecPkg::UCMD_LD, rvcDecPkg::IX_WORD,
					rdP, rs1P, rvcDecPkg::GR_IMM, {21'd0, off});
			end
			5'b01_000: setExpected(rvcDecPkg::UCMD_ALU, rvcDecPkg::IX_ADD, rd, rd,
				rvcDecPkg::GR_IMM, 33'($signed(ci6)));
			5'b01_010: setExpected(rvcDecPkg::UCMD_MOV, rvcDecPkg::IX_ADD, rd, rvcDecPkg::GR_ZZR,
				rvcDecPkg::GR_IMM, 33'($signed(ci6)));
			5'b01_011: if (ci6 != 6'd0 && w[11:7] != 5'd0 && w[11:7] != 5'd2)
				setExpected(rvcDecPkg::UCMD_MOV, rvcDecPkg::IX_LUI, rd, rvcDecPkg::GR_ZZR,
					rvcDecPkg::GR_IMM, 33'($signed(ci6)) << 12);
			5'b01_100: begin
				if (w[11] == 1'b0 && !w[12])	// srli, srai
					setExpected(rvcDecPkg::UCMD_ALU, w[10] ? rvcDecPkg::IX_SRA : rvcDecPkg::IX_SRL,
						rs1P, rs1P, rvcDecPkg::GR_IMM, {27'd0, ci6});
				else if (w[11:10] == 2'b10)
					setExpected(rvcDecPkg::UCMD_ALU, rvcDecPkg::IX_AND, rs1P, rs1P,
						rvcDecPkg::GR_IMM, 33'($signed(ci6)));
				else if (w[11:10] == 2'b11 && !w[12])
					setExpected(rvcDecPkg::UCMD_ALU, arIx, rs1P, rs1P, rdP, '0);
			end
			5'b01_101: begin	// offset[11|4|9:8|10|6|7|3:1|5]
				off[11] = w[12];
				off[4] = w[11];
				off[9:8] = w[10:9];
				off[10] = w[8];
				off[6] = w[7];
				off[7] = w[6];
				off[3:1] = w[5:3];
				off[5] = w[2];
				setExpected(rvcDecPkg::UCMD_JMP, rvcDecPkg::IX_ADD, rvcDecPkg::GR_ZZR,
					rvcDecPkg::GR_PC, rvcDecPkg::GR_IMM, 33'($signed(off)));
			end
			5'b01_110, 5'b01_111: begin	// offset[8|4:3] and [7:6|2:1|5]
				off[8] = w[12];
				off[4:3] = w[11:10];
				off[7:6] = w[6:5];
				off[2:1] = w[4:3];
				off[5] = w[2];
				setExpected(rvcDecPkg::UCMD_BRA, rvcDecPkg::IX_ADD, rs1P, rvcDecPkg::GR_PC,
					rvcDecPkg::GR_IMM, 33'($signed(off[8:0])));
				expCc = w[13] ? rvcDecPkg::IXC_NEZ : rvcDecPkg::IXC_EQZ;
			end
			5'b10_000: if (!w[12])
				setExpected(rvcDecPkg::UCMD_ALU, rvcDecPkg::IX_SLL, rd, rd,
					rvcDecPkg::GR_IMM, {27'd0, ci6});
			5'b10_010: begin	// uimm[5|4:2|7:6]
				off[5] = w[12];
				off[4:2] = w[6:4];
				off[7:6] = w[3:2];
				setExpected(rvcDecPkg::UCMD_LD, rvcDecPkg::IX_WORD, rd, 6'd2,
					rvcDecPkg::GR_IMM, {21'd0, off});
			end
			5'b10_110: begin	// uimm[5:2|7:6]
				off[5:2] = w[12:9];
				off[7:6] = w[8:7];
				setExpected(rvcDecPkg::UCMD_ST, rvcDecPkg::IX_WORD, rs2, 6'd2,
					rvcDecPkg::GR_IMM, {21'd0, off});
			end
			5'b10_100: begin
				if (w[6:2] != 5'd0)	// c.add, c.mv
					setExpected(w[12] ? rvcDecPkg::UCMD_ALU : rvcDecPkg::UCMD_MOV, rvcDecPkg::IX_ADD,
						rd, w[12] ? rd : rvcDecPkg::GR_ZZR, rs2, '0);
				else if (!w[12] && w[11:7] != 5'd0)	// c.jr
					setExpected(rvcDecPkg::UCMD_JMP, rvcDecPkg::IX_ADD, rvcDecPkg::GR_ZZR, rd,
						rvcDecPkg::GR_ZZR, '0);
				else if (w[12] && w[11:7] == 5'd0 && privOk)	// c.ebreak
					setExpected(rvcDecPkg::UCMD_TRAP, rvcDecPkg::IX_ADD, rvcDecPkg::GR_ZZR,
						rvcDecPkg::GR_ZZR, rvcDecPkg::GR_ZZR, '0);
			end
			default: ;
		endcase
	endfunction

	task automatic checkField(input string sig, input logic [32:0] got, input logic [32:0] want);
		checks++;
		assert (got === want) else begin
			$display("** Error %s: got 0x%h, expected 0x%h", sig, got, want);
			errors++;
		end
	endtask

	task automatic checkOutputs();
		checkField("idValid", 33'(idValid), 33'(1));
		checkField("idRegN", 33'(idRegN), 33'(expN));
		checkField("idRegM", 33'(idRegM), 33'(expM));
		checkField("idRegO", 33'(idRegO), 33'(expO));
		checkField("idImm", idImm, expImm);
		checkField("idUCmd", 33'(idUCmd), 33'({expCc, expOp}));
		checkField("idUIxt", 33'(idUIxt), 33'({expMem, 2'b00, expIx}));
		checkField("idInvalid", 33'(idInvalid), 33'(expOp == rvcDecPkg::UCMD_INVOP));
	endtask

	// called on a falling edge, returns on the next one
	task automatic issueWord(input logic [15:0] w, input logic [3:0] mode);
		istrWord = w;
		srMod = mode;
		issue = 1'b1;
		refDecode(w, mode);
		@(negedge clock);
		issue = 1'b0;
		checkOutputs();
	endtask

	task automatic finishTest(input string name, input int errBefore);
		tests++;
		$display("test %-8s done, %0d errors", name, errors - errBefore);
	endtask

	task automatic resetTest();
		int e0;
		e0 = errors;
		checkField("idValid", 33'(idValid), 33'(0));
		checkField("illegalSeen", 33'(illegalSeen), 33'(0));
		checkField("idUCmd", 33'(idUCmd), 33'({rvcDecPkg::IXC_AL, rvcDecPkg::UCMD_INVOP}));
		checkField("idRegN", 33'(idRegN), 33'(rvcDecPkg::GR_ZZR));
		checkField("idRegM", 33'(idRegM), 33'(rvcDecPkg::GR_ZZR));
		checkField("idRegO", 33'(idRegO), 33'(rvcDecPkg::GR_ZZR));
		finishTest("reset", e0);
	endtask

	task automatic arithTest();
		logic [4:0] rd;
		logic [4:0] rs;
		logic [2:0] pa;
		logic [2:0] pb;
		logic [5:0] im;
		int e0;
		e0 = errors;
		for (int r = 0; r < ROUNDS; r++) begin
			rd = 5'(randBits(5));
			rs = 5'(randBits(5));
			pa = 3'(randBits(3));
			pb = 3'(randBits(3));
			im = 6'(randBits(6));
			if (rs == 5'd0)
				rs = 5'd1;	// keep off the c.jr/c.ebreak slots
			issueWord({4'b1001, rd, rs, 2'b10}, USER_MODE);
			issueWord({4'b1000, rd, rs, 2'b10}, USER_MODE);
			for (int f = 0; f < 4; f++)
				issueWord({3'b100, 1'b0, 2'b11, pa, 2'(f), pb, 2'b01}, USER_MODE);
			issueWord({3'b000, im[5], rd, im[4:0], 2'b01}, USER_MODE);
			issueWord({3'b010, im[5], rd, im[4:0], 2'b01}, USER_MODE);
			issueWord({3'b100, 1'b0, 2'b00, pa, im[4:0], 2'b01}, USER_MODE);
			issueWord({3'b100, 1'b0, 2'b01, pa, im[4:0], 2'b01}, USER_MODE);
			issueWord({3'b100, im[5], 2'b10, pa, im[4:0], 2'b01}, USER_MODE);
			issueWord({3'b000, 1'b0, rd, im[4:0], 2'b10}, USER_MODE);
			if (im == 6'd0)
				im = 6'd1;
			if (rd == 5'd0 || rd == 5'd2)
				rd = 5'd3;
			issueWord({3'b011, im[5], rd, im[4:0], 2'b01}, USER_MODE);
		end
		finishTest("arith", e0);
	endtask

	task automatic memTest();
		logic [15:0] w;
		int e0;
		e0 = errors;
		for (int r = 0; r < ROUNDS; r++) begin
			issueWord({3'b010, 11'(randBits(11)), 2'b00}, USER_MODE);
			issueWord({3'b110, 11'(randBits(11)), 2'b00}, USER_MODE);
			issueWord({3'b010, 11'(randBits(11)), 2'b10}, USER_MODE);
			issueWord({3'b110, 11'(randBits(11)), 2'b10}, USER_MODE);
			w = {3'b000, 11'(randBits(11)), 2'b00};
			if (w[12:5] == 8'd0)
				w[5] = 1'b1;	// zero nzuimm is reserved
			issueWord(w, USER_MODE);
		end
		finishTest("memory", e0);
	endtask

	task automatic flowTest();
		logic [4:0] rs;
		int e0;
		e0 = errors;
		for (int r = 0; r < ROUNDS; r++) begin
			issueWord({3'b101, 11'(randBits(11)), 2'b01}, USER_MODE);
			issueWord({3'b110, 11'(randBits(11)), 2'b01}, USER_MODE);
			issueWord({3'b111, 11'(randBits(11)), 2'b01}, USER_MODE);
			rs = 5'(randBits(5));
			if (rs == 5'd0)
				rs = 5'd1;
			issueWord({4'b1000, rs, 5'd0, 2'b10}, USER_MODE);
		end
		finishTest("flow", e0);
	endtask

	task automatic illegalTest();
		int e0;
		e0 = errors;
		checkField("illegalSeen", 33'(illegalSeen), 33'(0));
		issueWord(FIRST_BAD, USER_MODE);
		checkField("illegalSeen", 33'(illegalSeen), 33'(1));
		checkField("illegalWord", 33'(illegalWord), 33'(FIRST_BAD));
		foreach (BAD_WORDS[i])
			issueWord(BAD_WORDS[i], USER_MODE);
		issueWord(16'h9002, DEBUG_MODE);	// ebreak allowed with the grant
		issueWord(16'h9002, SUPER_MODE);
		checkField("illegalSeen", 33'(illegalSeen), 33'(1));
		checkField("illegalWord", 33'(illegalWord), 33'(FIRST_BAD));
		finishTest("illegal", e0);
	endtask

	task automatic holdTest();
		int e0;
		e0 = errors;
		issueWord({3'b000, 1'b1, 5'd9, 5'd22, 2'b01}, USER_MODE);
		hold = 1'b1;
		istrWord = {3'b010, 1'b0, 5'd12, 5'd5, 2'b01};	// dropped under hold
		issue = 1'b1;
		repeat (2) begin
			@(negedge clock);
			checkOutputs();	// still the first word
		end
		hold = 1'b0;
		issueWord({3'b100, 1'b1, 2'b10, 3'd4, 5'd19, 2'b01}, USER_MODE);
		@(negedge clock);
		checkField("idValid", 33'(idValid), 33'(0));
		finishTest("hold", e0);
	endtask

	initial begin
		rstN = 1'b0;
		istrWord = '0;
		issue = 1'b0;
		srMod = SUPER_MODE;
		hold = 1'b0;
		lfsr = 16'd70;
		cycles = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		resetTest();
		arithTest();
		memTest();
		flowTest();
		illegalTest();
		holdTest();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/rvcDecPkg.sv
hdl/rvcFormatDecode.sv
hdl/rvcOperandSelect.sv
hdl/rvcDecodeLatch.sv
hdl/rvcDecodeStage.sv
sim/rvcDecodeStage_props.sv
sim/rvcDecodeStage_tb.sv
